// File: rtl/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// byte address width of the fetch ports and the memory bus
`define ADDR_WIDTH 16

// cache geometry
`define LINE_BYTES 16       // four instructions per line
`define N_SETS 8
`define N_WAYS 2

// memory request id, wraps after 16 requests
`define ID_WIDTH 4

// cycles from grant to response
`define MEM_LATENCY 4

// backing memory depth in 32-bit words
`define MEM_WORDS 1024

// addi x0, x0, 0
`define NOP_INSTR 32'h00000013

`endif

// File: rtl/icache_pkg.sv
`include "icache_config.svh"

package icache_pkg;

    typedef logic [`ADDR_WIDTH-1:0]         addr_t;
    typedef logic [31:0]                    word_t;
    typedef logic [`LINE_BYTES*8-1:0]       line_t;
    typedef logic [`ID_WIDTH-1:0]           mem_id_t;
    typedef logic [$clog2(`N_WAYS)-1:0]     way_t;

    // cache to arbiter, addr is line aligned
    typedef struct packed {
        logic       valid;
        addr_t      addr;
    } mem_req_t;

    // arbiter to cache
    typedef struct packed {
        logic       busy;
        mem_id_t    id;     // id given to the next accepted request
    } mem_grant_t;

    // memory to both caches
    typedef struct packed {
        logic       valid;
        mem_id_t    id;
        line_t      data;
    } mem_rsp_t;

    typedef struct packed {
        logic       aw_valid;
        addr_t      aw_addr;
        logic       w_valid;
        word_t      w_data;
        logic       b_ready;
        logic       ar_valid;
        addr_t      ar_addr;
        logic       r_ready;
    } axil_req_t;

    typedef struct packed {
        logic       aw_ready;
        logic       w_ready;
        logic       b_valid;
        logic       ar_ready;
        logic       r_valid;
        word_t      r_data;
    } axil_rsp_t;

    typedef enum logic {
        IDLE,                   // serving hits, miss goes out as a request
        REQUEST                 // waiting for the line with our id
    } cache_state_t;

    typedef enum logic [1:0] {
        AXIL_IDLE,
        AXIL_WRESP,
        AXIL_RDATA
    } axil_state_t;

endpackage

// File: rtl/victim_lfsr.sv
`timescale 1ns/1ps

module victim_lfsr import icache_pkg::*; #(
    parameter logic [15:0] SEED = 16'hace1      // must be nonzero
) (
    input  logic    clk,
    input  logic    rst,
    output way_t    o_way
);

    // x^16 + x^14 + x^13 + x^11 + 1, maximal length
    localparam logic [15:0] TAPS = 16'hb400;

    logic [15:0] lfsr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= SEED;
        end else if (lfsr[0]) begin
            lfsr <= {1'b0, lfsr[15:1]} ^ TAPS;
        end else begin
            lfsr <= {1'b0, lfsr[15:1]};
        end
    end

    assign o_way = lfsr[$bits(way_t)-1:0];

endmodule

// File: rtl/icache.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  addr_t       i_va,
    input  addr_t       i_pa,

    output logic        o_miss,
    output word_t       o_instr,

    output mem_req_t    o_mem_req,
    input  mem_grant_t  i_grant,
    input  mem_rsp_t    i_mem_rsp,
    input  way_t        i_victim
);

    localparam int OFFSET_BITS = $clog2(`LINE_BYTES);
    localparam int SET_BITS    = $clog2(`N_SETS);
    localparam int TAG_BITS    = `ADDR_WIDTH - OFFSET_BITS - SET_BITS;
    localparam int WSEL_BITS   = $clog2(`LINE_BYTES / 4);

    logic [TAG_BITS-1:0]    tag_mem   [`N_SETS][`N_WAYS];
    logic                   valid_mem [`N_SETS][`N_WAYS];
    line_t                  data_mem  [`N_SETS][`N_WAYS];

    logic [SET_BITS-1:0]    set_idx;
    logic [WSEL_BITS-1:0]   word_sel;
    logic [TAG_BITS-1:0]    req_tag;

    logic                   hit;
    way_t                   hit_way;
    logic                   has_free;
    way_t                   free_way;
    logic                   grant;
    logic                   rsp_match;

    cache_state_t           state;
    cache_state_t           next_state;

    // fill target, captured at the grant
    mem_id_t                fill_id;
    way_t                   fill_way;
    logic [SET_BITS-1:0]    fill_set;
    logic [TAG_BITS-1:0]    fill_tag;

    assign set_idx  = i_va[OFFSET_BITS +: SET_BITS];
    assign word_sel = i_va[2 +: WSEL_BITS];          // word aligned fetch
    assign req_tag  = i_pa[`ADDR_WIDTH-1 -: TAG_BITS];

    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        has_free = 1'b0;
        free_way = '0;
        for (int w = 0; w < `N_WAYS; w++) begin
            if (valid_mem[set_idx][w] && tag_mem[set_idx][w] == req_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
            if (!valid_mem[set_idx][w]) begin
                has_free = 1'b1;
                free_way = way_t'(w);
            end
        end
    end

    assign o_miss  = !hit;
    assign o_instr = hit ? data_mem[set_idx][hit_way][word_sel*32 +: 32] : `NOP_INSTR;

    // request the whole line on a miss
    always_comb begin
        o_mem_req.valid = (state == IDLE) && !hit;
        o_mem_req.addr  = {req_tag, set_idx, {OFFSET_BITS{1'b0}}};
    end

    assign grant     = o_mem_req.valid && !i_grant.busy;
    assign rsp_match = (state == REQUEST) && i_mem_rsp.valid && (i_mem_rsp.id == fill_id);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (grant) begin
                    next_state = REQUEST;
                end
            end
            REQUEST: begin
                if (rsp_match) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            for (int s = 0; s < `N_SETS; s++) begin
                for (int w = 0; w < `N_WAYS; w++) begin
                    valid_mem[s][w] <= 1'b0;
                end
            end
        end else begin
            state <= next_state;
            if (rsp_match) begin
                valid_mem[fill_set][fill_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            fill_id  <= i_grant.id;
            fill_way <= has_free ? free_way : i_victim;   // empty way first, else random
            fill_set <= set_idx;
            fill_tag <= req_tag;
        end
        if (rsp_match) begin
            tag_mem[fill_set][fill_way]  <= fill_tag;
            data_mem[fill_set][fill_way] <= i_mem_rsp.data;
        end
    end

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  mem_req_t    i_req0,
    input  mem_req_t    i_req1,
    output mem_grant_t  o_grant0,
    output mem_grant_t  o_grant1,

    output mem_req_t    o_mem_req,
    output mem_id_t     o_mem_id
);

    logic       grant0;
    logic       grant1;
    mem_id_t    id_q;

    // fixed priority, port 0 wins
    assign grant0 = i_req0.valid;
    assign grant1 = i_req1.valid && !i_req0.valid;

    always_comb begin
        o_grant0.busy = grant1;
        o_grant0.id   = id_q;
        o_grant1.busy = grant0;
        o_grant1.id   = id_q;
    end

    always_comb begin
        if (grant0) begin
            o_mem_req = i_req0;
        end else begin
            o_mem_req = i_req1;
        end
        o_mem_req.valid = grant0 || grant1;
    end

    assign o_mem_id = id_q;

    // one id per granted request, wraps freely
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_q <= '0;
        end else if (o_mem_req.valid) begin
            id_q <= id_q + 1'b1;
        end
    end

endmodule

// File: rtl/line_memory.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module line_memory import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  mem_req_t    i_req,
    input  mem_id_t     i_req_id,
    output mem_rsp_t    o_rsp,

    input  axil_req_t   i_axil,
    output axil_rsp_t   o_axil
);

    localparam int WORD_BITS = $clog2(`MEM_WORDS);
    localparam int LINE_WORDS = `LINE_BYTES / 4;

    word_t              ram [`MEM_WORDS];
    mem_rsp_t           rsp_pipe [`MEM_LATENCY];
    line_t              line_rd;
    logic [WORD_BITS-1:0] line_base;

    axil_state_t        axil_state;
    logic               wr_go;
    logic               rd_go;
    word_t              rdata_q;

    assign line_base = i_req.addr[2 +: WORD_BITS];

    // gather the whole line in one cycle
    always_comb begin
        for (int k = 0; k < LINE_WORDS; k++) begin
            line_rd[k*32 +: 32] = ram[line_base + WORD_BITS'(k)];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MEM_LATENCY; i++) begin
                rsp_pipe[i].valid <= 1'b0;
            end
        end else begin
            rsp_pipe[0].valid <= i_req.valid;
            rsp_pipe[0].id    <= i_req_id;
            rsp_pipe[0].data  <= line_rd;
            for (int i = 1; i < `MEM_LATENCY; i++) begin
                rsp_pipe[i] <= rsp_pipe[i-1];
            end
        end
    end

    assign o_rsp = rsp_pipe[`MEM_LATENCY-1];

    // write takes priority when both arrive together
    assign wr_go = (axil_state == AXIL_IDLE) && i_axil.aw_valid && i_axil.w_valid;
    assign rd_go = (axil_state == AXIL_IDLE) && i_axil.ar_valid && !wr_go;

    always_comb begin
        o_axil.aw_ready = wr_go;
        o_axil.w_ready  = wr_go;
        o_axil.b_valid  = (axil_state == AXIL_WRESP);
        o_axil.ar_ready = rd_go;
        o_axil.r_valid  = (axil_state == AXIL_RDATA);
        o_axil.r_data   = rdata_q;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            axil_state <= AXIL_IDLE;
        end else begin
            case (axil_state)
                AXIL_IDLE: begin
                    if (wr_go) axil_state <= AXIL_WRESP;
                    else if (rd_go) axil_state <= AXIL_RDATA;
                end
                AXIL_WRESP: if (i_axil.b_ready) axil_state <= AXIL_IDLE;
                AXIL_RDATA: if (i_axil.r_ready) axil_state <= AXIL_IDLE;
                default:    axil_state <= AXIL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            ram[i_axil.aw_addr[2 +: WORD_BITS]] <= i_axil.w_data;
        end
        if (rd_go) begin
            rdata_q <= ram[i_axil.ar_addr[2 +: WORD_BITS]];
        end
    end

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  addr_t       i_fetch_addr0,
    input  addr_t       i_fetch_addr1,
    output logic        o_miss0,
    output logic        o_miss1,
    output word_t       o_instr0,
    output word_t       o_instr1,

    input  axil_req_t   i_axil,
    output axil_rsp_t   o_axil
);

    mem_req_t   req0;
    mem_req_t   req1;
    mem_grant_t grant0;
    mem_grant_t grant1;
    mem_req_t   mem_req;
    mem_id_t    mem_id;
    mem_rsp_t   mem_rsp;          // broadcast to both caches
    way_t       victim0;
    way_t       victim1;

    victim_lfsr #(.SEED(16'hace1)) u_lfsr0 (.clk(clk), .rst(rst), .o_way(victim0));
    victim_lfsr #(.SEED(16'h1d5b)) u_lfsr1 (.clk(clk), .rst(rst), .o_way(victim1));

    // no translation, fetch address is index and tag
    icache u_icache0 (
        .clk       (clk),
        .rst       (rst),
        .i_va      (i_fetch_addr0),
        .i_pa      (i_fetch_addr0),
        .o_miss    (o_miss0),
        .o_instr   (o_instr0),
        .o_mem_req (req0),
        .i_grant   (grant0),
        .i_mem_rsp (mem_rsp),
        .i_victim  (victim0)
    );

    icache u_icache1 (
        .clk       (clk),
        .rst       (rst),
        .i_va      (i_fetch_addr1),
        .i_pa      (i_fetch_addr1),
        .o_miss    (o_miss1),
        .o_instr   (o_instr1),
        .o_mem_req (req1),
        .i_grant   (grant1),
        .i_mem_rsp (mem_rsp),
        .i_victim  (victim1)
    );

    mem_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .i_req0    (req0),
        .i_req1    (req1),
        .o_grant0  (grant0),
        .o_grant1  (grant1),
        .o_mem_req (mem_req),
        .o_mem_id  (mem_id)
    );

    line_memory u_memory (
        .clk      (clk),
        .rst      (rst),
        .i_req    (mem_req),
        .i_req_id (mem_id),
        .o_rsp    (mem_rsp),
        .i_axil   (i_axil),
        .o_axil   (o_axil)
    );

endmodule

// File: verif/tb_fetch_top.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module tb_fetch_top import icache_pkg::*; ();

    localparam int N_OPS         = 256 + 32 + 20;   // axi writes, readbacks, fetches
    localparam int FETCH_LIMIT   = 40;
    localparam int CONTEND_LIMIT = 2 * `MEM_LATENCY + 2;
    localparam int ANY_FETCH     = 0;
    localparam int COLD_FETCH    = 1;                // must start with a miss
    localparam int HIT_FETCH     = 2;                // must hit in the first cycle

    logic       clk;
    logic       rst;
    addr_t      fetch_addr0;
    addr_t      fetch_addr1;
    logic       miss0;
    logic       miss1;
    word_t      instr0;
    word_t      instr1;
    axil_req_t  axil_req;
    axil_rsp_t  axil_rsp;

    word_t       mirror [`MEM_WORDS];   // what the backing memory should hold
    logic [31:0] rng;

    fetch_top DUT (
        .clk           (clk),
        .rst           (rst),
        .i_fetch_addr0 (fetch_addr0),
        .i_fetch_addr1 (fetch_addr1),
        .o_miss0       (miss0),
        .o_miss1       (miss1),
        .o_instr0      (instr0),
        .o_instr1      (instr1),
        .i_axil        (axil_req),
        .o_axil        (axil_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rng = lfsr_next(rng);
            v   = {v[30:0], rng[0]};
        end
        return v;
    endfunction

    // byte address to word, wrapped to the memory depth
    function automatic word_t ref_word(input addr_t addr);
        return mirror[(addr >> 2) % `MEM_WORDS];
    endfunction

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %08h actual %08h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out after %0d cycles waiting for %s", FETCH_LIMIT, what);
        stop_on_failure();
    endtask

    task automatic axil_write(input addr_t addr, input word_t data);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        axil_req.aw_valid = 1'b1;
        axil_req.aw_addr  = addr;
        axil_req.w_valid  = 1'b1;
        axil_req.w_data   = data;
        #1;
        while (!axil_rsp.aw_ready) begin
            @(posedge clk);
            #2;
            n++;
            if (n > FETCH_LIMIT) report_timeout("the AXI write address handshake");
        end
        // address and data are taken together
        check_value("axil write data ready", 32'd1, 32'(axil_rsp.w_ready));
        @(posedge clk);
        #1;
        axil_req.aw_valid = 1'b0;
        axil_req.w_valid  = 1'b0;
        axil_req.b_ready  = 1'b1;
        #1;
        while (!axil_rsp.b_valid) begin
            @(posedge clk);
            #2;
            n++;
            if (n > FETCH_LIMIT) report_timeout("the AXI write response");
        end
        @(posedge clk);
        #1;
        axil_req.b_ready = 1'b0;
        mirror[(addr >> 2) % `MEM_WORDS] = data;
    endtask

    task automatic axil_read(input addr_t addr, output word_t data);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        axil_req.ar_valid = 1'b1;
        axil_req.ar_addr  = addr;
        #1;
        while (!axil_rsp.ar_ready) begin
            @(posedge clk);
            #2;
            n++;
            if (n > FETCH_LIMIT) report_timeout("the AXI read address handshake");
        end
        @(posedge clk);
        #1;
        axil_req.ar_valid = 1'b0;
        axil_req.r_ready  = 1'b1;
        #1;
        while (!axil_rsp.r_valid) begin
            @(posedge clk);
            #2;
            n++;
            if (n > FETCH_LIMIT) report_timeout("the AXI read data");
        end
        data = axil_rsp.r_data;
        @(posedge clk);
        #1;
        axil_req.r_ready = 1'b0;
    endtask

    // present an address, hold it until the miss clears, then check the word
    task automatic fetch(input int port, input addr_t addr, input int mode,
                         input string name, output int cycles);
        logic  miss;
        word_t instr;
        cycles = 0;
        @(posedge clk);
        #1;
        if (port == 0) fetch_addr0 = addr;
        else fetch_addr1 = addr;
        #1;
        miss  = (port == 0) ? miss0 : miss1;
        instr = (port == 0) ? instr0 : instr1;
        if (mode == COLD_FETCH) begin
            check_value({name, " miss flag"}, 32'd1, 32'(miss));
            check_value({name, " nop"}, `NOP_INSTR, instr);
        end else if (mode == HIT_FETCH) begin
            check_value({name, " miss flag"}, 32'd0, 32'(miss));
        end
        while (miss) begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > FETCH_LIMIT) report_timeout({name, " to leave the miss"});
            miss  = (port == 0) ? miss0 : miss1;
            instr = (port == 0) ? instr0 : instr1;
        end
        check_value(name, ref_word(addr), instr);
    endtask

    initial begin
        repeat (N_OPS * 50) @(posedge clk);
        $display("watchdog fired, the run took more than %0d cycles", N_OPS * 50);
        stop_on_failure();
    end

    initial begin
        addr_t addr;
        word_t rdata;
        int    cycles;
        int    c0;
        int    c1;

        rst         = 1'b1;
        fetch_addr0 = '0;       // both ports park on line 0, never checked
        fetch_addr1 = '0;
        axil_req    = '0;
        rng         = 32'h2d2f;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // program load over AXI4-Lite, then spot checks
        for (int i = 0; i < 256; i++) begin
            axil_write(addr_t'(i * 4), rand_bits(32));
        end
        for (int i = 0; i < 32; i++) begin
            addr = addr_t'(rand_bits(8) << 2);
            axil_read(addr, rdata);
            check_value("axil readback", ref_word(addr), rdata);
        end

        fetch(0, 16'h0094, COLD_FETCH, "cold miss", cycles);

        fetch(0, 16'h0090, HIT_FETCH, "line hit word 0", cycles);
        fetch(0, 16'h0098, HIT_FETCH, "line hit word 2", cycles);
        fetch(0, 16'h009c, HIT_FETCH, "line hit word 3", cycles);

        // three tags into set 2 of port 0, two ways
        fetch(0, 16'h0020, COLD_FETCH, "replace fill a", cycles);
        fetch(0, 16'h0124, COLD_FETCH, "replace fill b", cycles);
        fetch(0, 16'h0028, HIT_FETCH, "replace resident a", cycles);
        fetch(0, 16'h012c, HIT_FETCH, "replace resident b", cycles);
        fetch(0, 16'h0220, COLD_FETCH, "replace fill c", cycles);
        fetch(0, 16'h0224, HIT_FETCH, "replace resident c", cycles);
        fetch(0, 16'h002c, ANY_FETCH, "replace again a", cycles);
        fetch(0, 16'h0120, ANY_FETCH, "replace again b", cycles);
        fetch(0, 16'h0228, ANY_FETCH, "replace again c", cycles);

        fork
            fetch(0, 16'h0330, COLD_FETCH, "contention port 0", c0);
            fetch(1, 16'h03c4, COLD_FETCH, "contention port 1", c1);
        join
        if (c0 > CONTEND_LIMIT || c1 > CONTEND_LIMIT) begin
            $display("contention wait too long, port 0 took %0d and port 1 took %0d cycles",
                     c0, c1);
            stop_on_failure();
        end

        // the new word always differs from the old one
        axil_write(16'h02f8, ref_word(16'h02f8) ^ (rand_bits(32) | 32'h1));
        fetch(1, 16'h02f8, COLD_FETCH, "update visibility", cycles);

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: fetch_top.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/victim_lfsr.sv
rtl/icache.sv
rtl/mem_arbiter.sv
rtl/line_memory.sv
rtl/fetch_top.sv
verif/tb_fetch_top.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_fetch_top
RTL_TOP    ?= fetch_top
FILELIST   ?= fetch_top.f
MDIR       ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FILELIST)

run: build
	./$(MDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(MDIR) $(LOG)
